// ==== include/rvCore_defines.svh ====
`ifndef RV_CORE_DEFINES_SVH
`define RV_CORE_DEFINES_SVH

// Datapath width
`define RV_XLEN 32

// Architectural integer registers
`define RV_REG_COUNT 32

// Data memory depth in 32-bit words, power of two
`define RV_DMEM_WORDS 256

// First fetch address after reset
`define RV_RESET_PC 32'h0000_0000

`endif

// ==== design/rvPkg.sv ====
`default_nettype none

package rvPkg;

    typedef enum logic [3:0] {
        aluAdd = 4'b0000,
        aluSub = 4'b0001,
        aluAnd = 4'b0010,
        aluOr  = 4'b0011,
        aluSll = 4'b0100,
        aluSlt = 4'b0101,
        aluSrl = 4'b0110,
        aluSra = 4'b0111,
        aluGe  = 4'b1000, // 0 when a >= b signed
        aluXor = 4'b1001
    } aluCodeT;

    typedef enum logic [1:0] {
        opMem    = 2'b00,
        opBranch = 2'b01,
        opFunc   = 2'b10
    } aluOpT;

    typedef enum logic [1:0] {
        sizeWord = 2'b00,
        sizeByte = 2'b01,
        sizeHalf = 2'b10
    } dataSizeT;

    typedef enum logic [1:0] {
        resultAlu = 2'b00,
        resultMem = 2'b01,
        resultPc4 = 2'b10
    } resultSrcT;

    typedef enum logic [1:0] {
        immI = 2'b00,
        immS = 2'b01,
        immB = 2'b10,
        immJ = 2'b11
    } immSelT;

    typedef struct packed {
        dataSizeT size;
        logic     zeroExt;
    } memAccessT;

    typedef struct packed {
        logic      regWrite;
        logic      memWrite;
        logic      branch;
        logic      jump;
        logic      aluSrcImm;
        resultSrcT resultSrc;
        immSelT    immSel;
        aluOpT     aluOp;
        logic      altFunct; // Qualified instr[30]
    } ctrlT;

endpackage

`default_nettype wire

// ==== design/mainDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module mainDecoder (
    input  wire logic [6:0]  opcode,
    input  wire logic [2:0]  funct3,
    input  wire logic        instr30,
    output rvPkg::ctrlT      ctrl
);
    import rvPkg::*;

    localparam logic [6:0] opcodeR      = 7'b0110011;
    localparam logic [6:0] opcodeI      = 7'b0010011;
    localparam logic [6:0] opcodeLoad   = 7'b0000011;
    localparam logic [6:0] opcodeStore  = 7'b0100011;
    localparam logic [6:0] opcodeBranch = 7'b1100011;
    localparam logic [6:0] opcodeJal    = 7'b1101111;

    always_comb begin
        ctrl = '0; // Unknown opcodes leave every strobe low
        case (opcode)
            opcodeR: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = opFunc;
                ctrl.altFunct = instr30; // sub / sra
            end
            opcodeI: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.immSel    = immI;
                ctrl.aluOp     = opFunc;
                // Only srai uses bit 30, elsewhere it is immediate data
                ctrl.altFunct  = (funct3 == 3'b101) && instr30;
            end
            opcodeLoad: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.immSel    = immI;
                ctrl.resultSrc = resultMem;
                ctrl.aluOp     = opMem;
            end
            opcodeStore: begin
                ctrl.memWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.immSel    = immS;
                ctrl.aluOp     = opMem;
            end
            opcodeBranch: begin
                ctrl.branch = 1'b1;
                ctrl.immSel = immB;
                ctrl.aluOp  = opBranch; // Compare rs1 against rs2
            end
            opcodeJal: begin
                ctrl.regWrite  = 1'b1;
                ctrl.jump      = 1'b1;
                ctrl.immSel    = immJ;
                ctrl.resultSrc = resultPc4; // Link address
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== design/aluDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module aluDecoder (
    input  rvPkg::aluOpT      aluOp,
    input  wire logic [2:0]   funct3,
    input  wire logic         altFunct,
    output rvPkg::aluCodeT    aluCode,
    output rvPkg::memAccessT  memAccess
);
    import rvPkg::*;

    always_comb begin
        aluCode   = aluAdd;
        memAccess = '{size: sizeWord, zeroExt: 1'b0}; // Signed word
        case (aluOp)
            opMem: begin
                aluCode = aluAdd; // Base plus offset
                case (funct3[1:0])
                    2'b00:   memAccess.size = sizeByte;
                    2'b01:   memAccess.size = sizeHalf;
                    default: memAccess.size = sizeWord;
                endcase
                memAccess.zeroExt = funct3[2]; // lbu / lhu
            end
            opBranch: begin
                case (funct3)
                    3'b000:  aluCode = aluSub; // beq
                    3'b101:  aluCode = aluGe;  // bge
                    default: aluCode = aluAdd;
                endcase
            end
            opFunc: begin
                case (funct3)
                    3'b000: begin
                        if (altFunct) begin
                            aluCode = aluSub;
                        end else begin
                            aluCode = aluAdd;
                        end
                    end
                    3'b001:  aluCode = aluSll;
                    3'b010:  aluCode = aluSlt;
                    3'b100:  aluCode = aluXor;
                    3'b101: begin
                        if (altFunct) begin
                            aluCode = aluSra; // Arithmetic, keeps sign
                        end else begin
                            aluCode = aluSrl;
                        end
                    end
                    3'b110:  aluCode = aluOr;
                    3'b111:  aluCode = aluAnd;
                    default: aluCode = aluAdd;
                endcase
            end
            default: begin
                aluCode = aluAdd;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== design/immExtend.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rvCore_defines.svh"

module immExtend (
    input  wire logic [31:0]         instr,
    input  rvPkg::immSelT            immSel,
    output logic [`RV_XLEN-1:0]      imm
);
    import rvPkg::*;

    logic sign;

    assign sign = instr[31];

    always_comb begin
        case (immSel)
            immI: begin
                imm = {{20{sign}}, instr[31:20]};
            end
            immS: begin
                imm = {{20{sign}}, instr[31:25], instr[11:7]};
            end
            immB: begin
                // Halfword aligned branch offset
                imm = {{19{sign}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            immJ: begin
                imm = {{11{sign}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== design/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rvCore_defines.svh"

module alu (
    input  wire logic [`RV_XLEN-1:0] a,
    input  wire logic [`RV_XLEN-1:0] b,
    input  rvPkg::aluCodeT           aluCode,
    output logic [`RV_XLEN-1:0]      result,
    output logic                     zero
);
    import rvPkg::*;

    logic [4:0] shamt;
    logic       lessSigned;

    assign shamt      = b[4:0];
    assign lessSigned = $signed(a) < $signed(b);

    always_comb begin
        result = '0; // Unused codes
        case (aluCode)
            aluAdd: result = a + b;
            aluSub: result = a - b;
            aluAnd: result = a & b;
            aluOr:  result = a | b;
            aluXor: result = a ^ b;
            aluSll: result = a << shamt;
            aluSrl: result = a >> shamt;
            aluSra: result = $unsigned($signed(a) >>> shamt);
            aluSlt: result[0] = lessSigned;
            aluGe:  result[0] = lessSigned; // Zero when a >= b
            default: result = '0;
        endcase
    end

    // Branch condition for both beq and bge
    assign zero = (result == '0);

endmodule

`default_nettype wire

// ==== design/regFile.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rvCore_defines.svh"

module regFile (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic [4:0]         rs1Addr,
    input  wire logic [4:0]         rs2Addr,
    input  wire logic [4:0]         rdAddr,
    input  wire logic [`RV_XLEN-1:0] rdData,
    input  wire logic               we,
    output logic [`RV_XLEN-1:0]     rs1Data,
    output logic [`RV_XLEN-1:0]     rs2Data
);

    logic [`RV_XLEN-1:0] regs [`RV_REG_COUNT];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rdAddr != 5'd0)) begin // x0 writes dropped
            regs[rdAddr] <= rdData;
        end
    end

    assign rs1Data = (rs1Addr == 5'd0) ? '0 : regs[rs1Addr];
    assign rs2Data = (rs2Addr == 5'd0) ? '0 : regs[rs2Addr];

endmodule

`default_nettype wire

// ==== design/dataMemory.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rvCore_defines.svh"

module dataMemory (
    input  wire logic                clk,
    input  wire logic [`RV_XLEN-1:0] addr,
    input  wire logic [`RV_XLEN-1:0] wData,
    input  wire logic                we,
    input  rvPkg::memAccessT         memAccess,
    output logic [`RV_XLEN-1:0]      rData
);
    import rvPkg::*;

    localparam int IdxW = $clog2(`RV_DMEM_WORDS);

    logic [31:0]     mem [`RV_DMEM_WORDS];
    logic [IdxW-1:0] wordIdx;
    logic [3:0]      byteEn;
    logic [31:0]     wLanes;
    logic [31:0]     rWord;
    logic [7:0]      rByte;
    logic [15:0]     rHalf;

    assign wordIdx = addr[IdxW+1:2]; // Wraps at memory depth

    always_comb begin
        case (memAccess.size)
            sizeByte: begin
                byteEn = 4'b0001 << addr[1:0];
                wLanes = {4{wData[7:0]}};
            end
            sizeHalf: begin
                byteEn = addr[1] ? 4'b1100 : 4'b0011;
                wLanes = {2{wData[15:0]}};
            end
            default: begin
                byteEn = 4'b1111;
                wLanes = wData;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (we) begin
            for (int i = 0; i < 4; i++) begin
                if (byteEn[i]) begin
                    mem[wordIdx][8*i +: 8] <= wLanes[8*i +: 8];
                end
            end
        end
    end

    assign rWord = mem[wordIdx];
    assign rByte = rWord[8*addr[1:0] +: 8];
    assign rHalf = addr[1] ? rWord[31:16] : rWord[15:0];

    always_comb begin
        case (memAccess.size)
            sizeByte: rData = memAccess.zeroExt ? {24'b0, rByte} : {{24{rByte[7]}}, rByte};
            sizeHalf: rData = memAccess.zeroExt ? {16'b0, rHalf} : {{16{rHalf[15]}}, rHalf};
            default:  rData = rWord;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/rvCore.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rvCore_defines.svh"

module rvCore (
    input  wire logic                clk,
    input  wire logic                rst,
    output logic [`RV_XLEN-1:0]      instrAddr,
    input  wire logic [31:0]         instr,
    output logic                     storeValid,
    output logic [`RV_XLEN-1:0]      storeAddr,
    output logic [`RV_XLEN-1:0]      storeData,
    output rvPkg::dataSizeT          storeSize
);
    import rvPkg::*;

    ctrlT                ctrl;
    aluCodeT             aluCode;
    memAccessT           memAccess;
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] pcPlus4;
    logic [`RV_XLEN-1:0] pcTarget;
    logic [`RV_XLEN-1:0] pcNext;
    logic [`RV_XLEN-1:0] imm;
    logic [`RV_XLEN-1:0] rs1Data;
    logic [`RV_XLEN-1:0] rs2Data;
    logic [`RV_XLEN-1:0] aluB;
    logic [`RV_XLEN-1:0] aluResult;
    logic [`RV_XLEN-1:0] readData;
    logic [`RV_XLEN-1:0] wbData;
    logic                zero;
    logic                takeTarget;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `RV_RESET_PC;
        end else begin
            pc <= pcNext;
        end
    end

    assign pcPlus4    = pc + 32'd4;
    assign pcTarget   = pc + imm; // B or J offset, per immSel
    assign takeTarget = ctrl.jump || (ctrl.branch && zero);
    assign pcNext     = takeTarget ? pcTarget : pcPlus4;
    assign instrAddr  = pc;

    mainDecoder mainDec (
        .opcode  (instr[6:0]),
        .funct3  (instr[14:12]),
        .instr30 (instr[30]),
        .ctrl    (ctrl)
    );

    aluDecoder aluDec (
        .aluOp     (ctrl.aluOp),
        .funct3    (instr[14:12]),
        .altFunct  (ctrl.altFunct),
        .aluCode   (aluCode),
        .memAccess (memAccess)
    );

    immExtend immExt (
        .instr  (instr),
        .immSel (ctrl.immSel),
        .imm    (imm)
    );

    regFile regs (
        .clk     (clk),
        .rst     (rst),
        .rs1Addr (instr[19:15]),
        .rs2Addr (instr[24:20]),
        .rdAddr  (instr[11:7]),
        .rdData  (wbData),
        .we      (ctrl.regWrite),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data)
    );

    assign aluB = ctrl.aluSrcImm ? imm : rs2Data;

    alu aluUnit (
        .a       (rs1Data),
        .b       (aluB),
        .aluCode (aluCode),
        .result  (aluResult),
        .zero    (zero)
    );

    dataMemory dmem (
        .clk       (clk),
        .addr      (aluResult),
        .wData     (rs2Data),
        .we        (storeValid),
        .memAccess (memAccess),
        .rData     (readData)
    );

    always_comb begin
        case (ctrl.resultSrc)
            resultMem: wbData = readData;
            resultPc4: wbData = pcPlus4; // jal link
            default:   wbData = aluResult;
        endcase
    end

    // Store observation copy
    assign storeValid = ctrl.memWrite && !rst;
    assign storeAddr  = aluResult;
    assign storeData  = rs2Data;
    assign storeSize  = memAccess.size;

endmodule

`default_nettype wire

// ==== tb/rvRefModel.svh ====
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

localparam logic [6:0] codeR      = 7'b0110011;
localparam logic [6:0] codeImm    = 7'b0010011;
localparam logic [6:0] codeLoad   = 7'b0000011;
localparam logic [6:0] codeStore  = 7'b0100011;
localparam logic [6:0] codeBranch = 7'b1100011;
localparam logic [6:0] codeJal    = 7'b1101111;

// add sub and or xor sll srl sra slt
localparam logic [2:0] funcF3 [9] = '{3'd0, 3'd0, 3'd7, 3'd6, 3'd4, 3'd1, 3'd5, 3'd5, 3'd2};
localparam logic       funcAlt [9] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0};
// addi slti xori ori andi
localparam logic [2:0] immF3 [5] = '{3'd0, 3'd2, 3'd4, 3'd6, 3'd7};

logic [31:0] refRegs [32];
logic [7:0]  refMem [1024]; // Byte image, wraps like the 256 word memory
logic [31:0] refPc;
logic        expStore;
logic [31:0] expAddr;
logic [31:0] expData;
dataSizeT    expSize;
int          progLen = 0;
int          slot;
int          seed;

function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2, rs1,
        input logic [2:0] f3, input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, codeR};
endfunction

function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
        input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2, rs1,
        input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], codeStore};
endfunction

function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2, rs1,
        input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], codeBranch};
endfunction

function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, codeJal};
endfunction

// RV32I integer result by funct3, alt selects sub or sra
function automatic logic [31:0] isaOp(input logic [2:0] f3, input logic alt,
        input logic [31:0] a, b);
    logic [31:0] fill;
    fill = a[31] ? ~(32'hFFFF_FFFF >> b[4:0]) : 32'd0;
    case (f3)
        3'b000:  return alt ? a - b : a + b;
        3'b001:  return a << b[4:0];
        3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'b100:  return a ^ b;
        3'b101:  return alt ? ((a >> b[4:0]) | fill) : (a >> b[4:0]);
        3'b110:  return a | b;
        3'b111:  return a & b;
        default: return 32'd0;
    endcase
endfunction

task automatic emit(input logic [31:0] word);
    rom[progLen[9:0]] = word;
    progLen++;
endtask

// 32-bit constant without lui, one byte at a time
task automatic loadConst(input logic [4:0] rd, input logic [31:0] v);
    emit(encI({4'h0, v[31:24]}, 5'd0, 3'b000, rd, codeImm));
    for (int i = 2; i >= 0; i--) begin
        emit(encI(12'd8, rd, 3'b001, rd, codeImm));
        emit(encI({4'h0, v[8*i +: 8]}, rd, 3'b110, rd, codeImm));
    end
endtask

task automatic storeResult(input logic [4:0] rs);
    emit(encS(slot[11:0], rs, 5'd31, 3'b010)); // Result area at x31
    slot += 4;
endtask

// Taken branch skips the second write of x12
task automatic branchCase(input logic [2:0] f3, input logic [11:0] va, vb);
    emit(encI(va, 5'd0, 3'b000, 5'd10, codeImm));
    emit(encI(vb, 5'd0, 3'b000, 5'd11, codeImm));
    emit(encI(12'h055, 5'd0, 3'b000, 5'd12, codeImm));
    emit(encB(13'd8, 5'd11, 5'd10, f3));
    emit(encI(12'h066, 5'd0, 3'b000, 5'd12, codeImm));
    storeResult(5'd12);
endtask

task automatic buildProgram();
    logic [31:0] v1;
    logic [31:0] v2;
    logic [11:0] imm;
    seed = 75098;
    slot = 0;
    for (int i = 0; i < 1024; i++) begin
        rom[i] = encI(i[11:0], 5'd0, 3'b000, 5'd0, codeImm);
    end
    emit(encS(12'd0, 5'd0, 5'd0, 3'b010)); // Store sits at the reset PC during reset
    emit(encI(12'h100, 5'd0, 3'b000, 5'd31, codeImm));
    emit(encI(12'h040, 5'd0, 3'b000, 5'd28, codeImm));
    emit(encI(12'h123, 5'd0, 3'b000, 5'd0, codeImm)); // Write to x0
    storeResult(5'd0);
    for (int n = 0; n < 5; n++) begin
        v1 = $random(seed);
        v2 = $random(seed);
        v1[31] = n[0]; // Both signs for sra
        loadConst(5'd1, v1);
        loadConst(5'd2, v2);
        for (int k = 0; k < 9; k++) begin
            emit(encR(funcAlt[k] ? 7'h20 : 7'h00, 5'd2, 5'd1, funcF3[k], 5'd3));
            storeResult(5'd3);
        end
        for (int k = 0; k < 5; k++) begin
            v2 = $random(seed);
            imm = v2[11:0];
            if (k == 0) begin
                imm[10] = 1'b1; // addi with instruction bit 30 set
            end
            emit(encI(imm, 5'd1, immF3[k], 5'd3, codeImm));
            storeResult(5'd3);
        end
        emit(encI({7'h00, v2[20:16]}, 5'd1, 3'b001, 5'd3, codeImm));
        storeResult(5'd3);
        emit(encI({7'h00, v2[20:16]}, 5'd1, 3'b101, 5'd3, codeImm));
        storeResult(5'd3);
        emit(encI({7'h20, v2[20:16]}, 5'd1, 3'b101, 5'd3, codeImm));
        storeResult(5'd3);
    end
    v1 = $random(seed) | 32'h0000_8080;
    v2 = $random(seed) | 32'h8000_0000;
    loadConst(5'd5, v1);
    loadConst(5'd6, v2);
    for (int k = 0; k < 4; k++) begin
        emit(encS(12'(k * 4), 5'd6, 5'd28, 3'b010));
    end
    for (int k = 0; k < 4; k++) begin
        emit(encS(12'(k), 5'd5, 5'd28, 3'b000)); // sb at every offset
    end
    emit(encS(12'd4, 5'd5, 5'd28, 3'b001));
    emit(encS(12'd6, 5'd5, 5'd28, 3'b001));
    emit(encS(12'd11, 5'd6, 5'd28, 3'b000));
    emit(encS(12'd14, 5'd5, 5'd28, 3'b001));
    for (int k = 0; k < 16; k++) begin
        emit(encI(12'(k), 5'd28, 3'b000, 5'd7, codeLoad));
        storeResult(5'd7);
        emit(encI(12'(k), 5'd28, 3'b100, 5'd7, codeLoad));
        storeResult(5'd7);
    end
    for (int k = 0; k < 8; k++) begin
        emit(encI(12'(k * 2), 5'd28, 3'b001, 5'd7, codeLoad));
        storeResult(5'd7);
        emit(encI(12'(k * 2), 5'd28, 3'b101, 5'd7, codeLoad));
        storeResult(5'd7);
    end
    for (int k = 0; k < 4; k++) begin
        emit(encI(12'(k * 4), 5'd28, 3'b010, 5'd7, codeLoad));
        storeResult(5'd7);
    end
    branchCase(3'b000, 12'd7, 12'd7);
    branchCase(3'b000, 12'd7, 12'hFFD);
    branchCase(3'b101, 12'd5, 12'd3);
    branchCase(3'b101, 12'd3, 12'd5);
    branchCase(3'b101, 12'hFFE, 12'd3);
    branchCase(3'b101, 12'd3, 12'hFFE);
    branchCase(3'b101, 12'hFFB, 12'hFFB);
    branchCase(3'b101, 12'hFFF, 12'hFF9);
    branchCase(3'b101, 12'hFF9, 12'hFFF);
    for (int k = 0; k < 3; k++) begin
        v1 = $random(seed);
        branchCase(3'b101, v1[11:0], v1[27:16]);
    end
    branchCase(3'b000, v1[11:0], v1[11:0]);
    emit(encJ(21'd12, 5'd0));                        // Forward over two
    emit(encI(12'd9, 5'd0, 3'b000, 5'd14, codeImm));
    emit(encJ(21'd8, 5'd0));
    emit(encJ(21'h1F_FFF8, 5'd15));                  // Back by 8, link in x15
    storeResult(5'd15);
    storeResult(5'd14);
    emit(encJ(21'd8, 5'd1));
    emit(encI(12'd1, 5'd0, 3'b000, 5'd1, codeImm));
    storeResult(5'd1);
    emit(encR(7'h00, 5'd2, 5'd1, 3'b000, 5'd0));
    emit(encI(12'd0, 5'd28, 3'b010, 5'd0, codeLoad));
    storeResult(5'd0);
    haltPc = progLen * 4;
    emit(encJ(21'd0, 5'd0)); // Self loop
endtask

task automatic predictStore();
    logic [31:0] ins;
    ins      = rom[refPc[11:2]];
    expStore = (ins[6:0] == codeStore);
    expAddr  = refRegs[ins[19:15]] + {{20{ins[31]}}, ins[31:25], ins[11:7]};
    expData  = refRegs[ins[24:20]];
    case (ins[13:12])
        2'b00:   expSize = sizeByte;
        2'b01:   expSize = sizeHalf;
        default: expSize = sizeWord;
    endcase
    if (expStore) begin
        storesSeen++;
    end
endtask

task automatic resetModel();
    refPc = `RV_RESET_PC;
    for (int i = 0; i < 32; i++) begin
        refRegs[i] = 32'd0;
    end
    predictStore();
endtask

// Retires the instruction at refPc
task automatic stepModel();
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] addr;
    logic [31:0] res;
    logic [31:0] nextPc;
    logic [9:0]  ba;
    logic [7:0]  m0;
    logic [7:0]  m1;
    logic        wr;
    ins    = rom[refPc[11:2]];
    a      = refRegs[ins[19:15]];
    b      = refRegs[ins[24:20]];
    nextPc = refPc + 32'd4;
    res    = 32'd0;
    wr     = 1'b0;
    case (ins[6:0])
        codeR: begin
            res = isaOp(ins[14:12], ins[30], a, b);
            wr  = 1'b1;
        end
        codeImm: begin
            res = isaOp(ins[14:12], (ins[14:12] == 3'b101) && ins[30], a,
                        {{20{ins[31]}}, ins[31:20]});
            wr  = 1'b1;
        end
        codeLoad: begin
            addr = a + {{20{ins[31]}}, ins[31:20]};
            ba   = addr[9:0];
            m0   = refMem[ba];
            m1   = refMem[ba + 10'd1];
            case (ins[14:12])
                3'b000:  res = {{24{m0[7]}}, m0};
                3'b001:  res = {{16{m1[7]}}, m1, m0};
                3'b010:  res = {refMem[ba + 10'd3], refMem[ba + 10'd2], m1, m0};
                3'b100:  res = {24'd0, m0};
                3'b101:  res = {16'd0, m1, m0};
                default: res = 32'd0;
            endcase
            wr = 1'b1;
        end
        codeStore: begin
            addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
            ba   = addr[9:0];
            refMem[ba] = b[7:0];
            if (ins[14:12] != 3'b000) begin
                refMem[ba + 10'd1] = b[15:8];
            end
            if (ins[14:12] == 3'b010) begin
                refMem[ba + 10'd2] = b[23:16];
                refMem[ba + 10'd3] = b[31:24];
            end
        end
        codeBranch: begin
            if ((ins[14:12] == 3'b000 && a == b) ||
                    (ins[14:12] == 3'b101 && $signed(a) >= $signed(b))) begin
                nextPc = refPc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            end
        end
        codeJal: begin
            res    = refPc + 32'd4;
            wr     = 1'b1;
            nextPc = refPc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        end
        default: begin
            wr = 1'b0;
        end
    endcase
    if (wr && ins[11:7] != 5'd0) begin
        refRegs[ins[11:7]] = res;
    end
    refPc = nextPc;
endtask

`endif

// ==== tb/rvCoreTb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rvCore_defines.svh"

module rvCoreTb;
    import rvPkg::*;

    localparam int ClkPeriod   = 8;
    localparam int ResetCycles = 4;

    logic        clk;
    logic        rst;
    logic [31:0] instrAddr;
    logic [31:0] instr;
    logic        storeValid;
    logic [31:0] storeAddr;
    logic [31:0] storeData;
    dataSizeT    storeSize;

    logic [31:0] rom [1024];
    logic [31:0] haltPc;
    int          errors     = 0;
    int          cycles     = 0;
    int          storesSeen = 0;

    `include "rvRefModel.svh"

    rvCore UUT (
        .clk        (clk),
        .rst        (rst),
        .instrAddr  (instrAddr),
        .instr      (instr),
        .storeValid (storeValid),
        .storeAddr  (storeAddr),
        .storeData  (storeData),
        .storeSize  (storeSize)
    );

    assign instr = rom[instrAddr[11:2]]; // Combinational fetch

    task automatic reportMismatch(input string what, input logic [31:0] got,
            input logic [31:0] want);
        errors++;
        $display("FAILED at %0t: %s is %h, model expects %h", $time, what, got, want);
    endtask

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    noStoreInReset: assert property (@(posedge clk) rst |-> !storeValid)
        else reportMismatch("storeValid during reset", {31'd0, $sampled(storeValid)}, 32'd0);

    pcAfterReset: assert property (@(posedge clk) $fell(rst) |-> instrAddr == `RV_RESET_PC)
        else reportMismatch("instrAddr after reset", $sampled(instrAddr), `RV_RESET_PC);

    pcFollowsModel: assert property (@(posedge clk) disable iff (rst) instrAddr == refPc)
        else reportMismatch("instrAddr", $sampled(instrAddr), $sampled(refPc));

    storeSeen: assert property (@(posedge clk) disable iff (rst) expStore |-> storeValid)
        else reportMismatch("storeValid", {31'd0, $sampled(storeValid)}, 32'd1);

    storeAddrOk: assert property (@(posedge clk) disable iff (rst)
            expStore |-> storeAddr == expAddr)
        else reportMismatch("storeAddr", $sampled(storeAddr), $sampled(expAddr));

    storeDataOk: assert property (@(posedge clk) disable iff (rst)
            expStore |-> storeData == expData)
        else reportMismatch("storeData", $sampled(storeData), $sampled(expData));

    storeSizeOk: assert property (@(posedge clk) disable iff (rst)
            expStore |-> storeSize == expSize)
        else reportMismatch("storeSize", {30'd0, $sampled(storeSize)},
                            {30'd0, $sampled(expSize)});

    noSpuriousStore: assert property (@(posedge clk) disable iff (rst)
            !expStore |-> !storeValid)
        else reportMismatch("storeValid", {31'd0, $sampled(storeValid)}, 32'd0);

    initial begin
        rst = 1'b1;
        buildProgram();
        resetModel();
        repeat (ResetCycles) @(posedge clk);
        #1;
        rst = 1'b0;
        while (refPc != haltPc) begin
            @(posedge clk);
            #1;
            stepModel();
            predictStore();
            cycles++;
        end
        @(posedge clk); // Halt loop gets checked once
        #1;
        $display("Cycles: %0d, stores: %0d, errors: %0d", cycles, storesSeen, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // Every instruction retires at most once
    initial begin
        wait (progLen != 0);
        #((progLen + ResetCycles + 20) * ClkPeriod);
        $display("Timeout: the core did not reach the end of the program in time");
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+include
+incdir+tb
design/rvPkg.sv
design/mainDecoder.sv
design/aluDecoder.sv
design/immExtend.sv
design/alu.sv
design/regFile.sv
design/dataMemory.sv
design/rvCore.sv
tb/rvCoreTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= rvCoreTb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= *** TEST FAILED ***
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -qF "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
